/* sys_unit.f */
+incdir+dv
src/sys_pkg.sv
src/sys_decode.sv
src/csr_file.sv
src/trap_unit.sv
src/sys_unit.sv
dv/sys_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sys_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sys_unit.f \
        --top-module sys_unit_tb -o sim_sys_unit; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/sim_sys_unit 2>&1); then
    printf '%s\n' "$sim_out"
    echo "Simulation exited with an error"
    exit 1
fi

printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* dv/csr_model.svh */
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// Expected machine-mode state, advanced once per clock edge
logic [1:0] m_priv;
logic [63:0] m_mstatus;
logic [31:0] m_mie;
logic [31:0] m_mip;
logic [63:0] m_mtvec;
logic [63:0] m_mscratch;
logic [63:0] m_mepc;
logic [63:0] m_mcause;
logic [63:0] m_mtval;
logic [63:0] m_mcycle;
logic [63:0] m_minstret;
logic m_tbuf;
logic [15:0] m_pbuf;

task automatic model_reset();
    m_priv = PRIV_M;
    m_mstatus = 64'h1800;
    m_mie = '0;
    m_mip = '0;
    m_mtvec = '0;
    m_mscratch = '0;
    m_mepc = '0;
    m_mcause = '0;
    m_mtval = '0;
    m_mcycle = '0;
    m_minstret = '0;
    m_tbuf = 1'b0;
    m_pbuf = '0;
endtask

function automatic logic [63:0] model_read(input logic [11:0] addr, output logic known);
    known = 1'b1;
    case (addr)
        CSR_MSTATUS: return m_mstatus;
        CSR_MISA: return MISA_VALUE;
        CSR_MIE: return 64'(m_mie);
        CSR_MTVEC: return m_mtvec;
        CSR_MSCRATCH: return m_mscratch;
        CSR_MEPC: return m_mepc;
        CSR_MCAUSE: return m_mcause;
        CSR_MTVAL: return m_mtval;
        CSR_MIP: return 64'(m_mip);
        CSR_MCYCLE, CSR_CYCLE, CSR_TIME: return m_mcycle;
        CSR_MINSTRET, CSR_INSTRET: return m_minstret;
        CSR_MVENDORID: return MVENDORID;
        CSR_MARCHID: return MARCHID;
        CSR_MIMPID: return MIMPID;
        CSR_MHARTID: return 64'h0;
        default: begin
            known = 1'b0;
            return 64'h0;
        end
    endcase
endfunction

// Predicts the outputs of one slot, then applies the edge that ends it
task automatic model_cycle(input logic valid, input logic [31:0] ins, input logic [63:0] ipc,
                           input logic [63:0] src, input logic retired, input logic t_int,
                           input logic [15:0] p_ints, output wb_t ewb, output redirect_t eredir);
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [2:0] f3;
    logic [11:0] addr;
    logic is_csr;
    logic is_priv;
    logic is_mret;
    logic known;
    logic illegal;
    logic writes;
    logic reads;
    logic irq;
    logic trap;
    logic [63:0] old;
    logic [63:0] opnd;
    logic [63:0] nval;
    logic [63:0] cause;
    logic [31:0] pend;
    logic [31:0] fresh;
    rd = ins[11:7];
    rs1 = ins[19:15];
    f3 = ins[14:12];
    addr = ins[31:20];
    is_csr = valid && ins[6:0] == 7'h73 && f3 != 3'b000 && f3 != 3'b100;
    is_priv = valid && ins[6:0] == 7'h73 && f3 == 3'b000 && rd == 5'd0 && rs1 == 5'd0;
    is_mret = is_priv && addr == 12'h302;
    writes = f3[1:0] == 2'b01 || rs1 != 5'd0;
    reads = f3[1:0] != 2'b01 || rd != 5'd0;
    old = model_read(addr, known);
    illegal = valid && !is_csr && !(is_priv && (addr[11:1] == 11'd0 || is_mret));
    if (is_csr && (!known || m_priv == PRIV_U || addr[9:8] > m_priv
                   || (writes && addr[11:10] == 2'b11))) begin
        illegal = 1'b1;
    end

    // Platform lines outrank the timer, lowest line first
    pend = m_mip & m_mie;
    irq = valid && m_mstatus[3] && pend != 32'd0;
    cause = 64'd0;
    if (irq) begin
        cause = {1'b1, 63'd7};
        for (int i = 15; i >= 0; i--) begin
            if (pend[16 + i]) begin
                cause = {1'b1, 63'(16 + i)};
            end
        end
    end else if (illegal) begin
        cause = 64'd2;
    end else if (is_priv && addr == 12'h000) begin
        cause = (m_priv == PRIV_M) ? 64'd11 : 64'd8;
    end else if (is_priv && addr == 12'h001) begin
        cause = 64'd3;
    end
    trap = irq || illegal || (is_priv && addr[11:1] == 11'd0);

    ewb = '0;
    eredir = '0;
    if (trap) begin
        eredir.valid = 1'b1;
        eredir.pc = {m_mtvec[63:2], 2'b00};
    end else if (is_mret) begin
        eredir.valid = 1'b1;
        eredir.pc = m_mepc;
    end else if (is_csr && reads && rd != 5'd0) begin
        ewb.valid = 1'b1;
        ewb.rd = rd;
        ewb.data = old;
    end

    opnd = f3[2] ? 64'(rs1) : src;
    case (f3[1:0])
        2'b01: nval = opnd;
        2'b10: nval = old | opnd;
        default: nval = old & ~opnd;
    endcase

    // Lines reach mip one edge after they are buffered
    fresh = {m_pbuf, 8'h00, m_tbuf, 7'h00};
    m_mip = (m_mip & 32'hFFFF_0000) | fresh;
    m_tbuf = t_int;
    m_pbuf = p_ints;
    m_mcycle = m_mcycle + 64'd1;
    if (retired) begin
        m_minstret = m_minstret + 64'd1;
    end

    if (trap) begin
        m_mcause = cause;
        m_mtval = (cause == 64'd3) ? ipc : 64'd0;
        m_mepc = ipc;
        m_mstatus[12:11] = m_priv;
        m_mstatus[7] = m_mstatus[3];
        m_mstatus[3] = 1'b0;
        m_priv = PRIV_M;
    end else if (is_mret) begin
        m_priv = m_mstatus[12:11];
        m_mstatus[3] = m_mstatus[7];
        m_mstatus[7] = 1'b1;
        m_mstatus[12:11] = PRIV_U;
    end else if (is_csr && writes) begin
        case (addr)
            CSR_MSTATUS: m_mstatus = (nval & 64'h88) | (nval[12:11] != 2'b00 ? 64'h1800 : 64'h0);
            CSR_MIE: m_mie = nval[31:0] & 32'hFFFF_0080;
            CSR_MTVEC: m_mtvec = nval & ~64'h3;
            CSR_MSCRATCH: m_mscratch = nval;
            CSR_MEPC: m_mepc = nval & ~64'h1;
            CSR_MCAUSE: m_mcause = nval;
            CSR_MTVAL: m_mtval = nval;
            CSR_MIP: m_mip = (nval[31:0] & 32'hFFFF_0000) | fresh;
            CSR_MCYCLE: m_mcycle = nval;
            CSR_MINSTRET: m_minstret = nval;
            default: ;
        endcase
    end
endtask

`endif

/* dv/sys_unit_tb.sv */
`timescale 1ns/100ps

module sys_unit_tb import sys_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int NUM_SLOTS = 2000;
    localparam int TIMEOUT_CYCLES = NUM_SLOTS * 4 + RESET_CYCLES;

    logic clk;
    logic rst;
    logic instr_valid;
    logic [31:0] instr;
    logic [ALEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic inst_retired;
    logic mtime_int;
    logic [PLATFORM_INTR_LEN-1:0] platform_ints;
    wb_t wb;
    redirect_t redirect;
    logic [1:0] priv;

    logic [31:0] lfsr;
    logic [63:0] next_pc;
    logic mtime_next;
    logic [15:0] plat_next;
    int cycle_count;

    `include "csr_model.svh"

    sys_unit i_sys_unit (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .inst_retired  (inst_retired),
        .mtime_int     (mtime_int),
        .platform_ints (platform_ints),
        .wb            (wb),
        .redirect      (redirect),
        .priv          (priv)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "check failed");
        end
    endtask

    function automatic logic [31:0] csr_word(input logic [2:0] f3, input logic [11:0] addr,
                                             input logic [4:0] rd, input logic [4:0] rs1);
        return {addr, rs1, f3, rd, OPC_SYSTEM};
    endfunction

    function automatic logic [11:0] pick_addr(input logic [4:0] sel);
        case (sel)
            5'd0, 5'd18, 5'd31: return CSR_MSTATUS;
            5'd1: return CSR_MISA;
            5'd2, 5'd19: return CSR_MIE;
            5'd3, 5'd20: return CSR_MTVEC;
            5'd4, 5'd21, 5'd30: return CSR_MSCRATCH;
            5'd5, 5'd22: return CSR_MEPC;
            5'd6: return CSR_MCAUSE;
            5'd7: return CSR_MTVAL;
            5'd8, 5'd23: return CSR_MIP;
            5'd9: return CSR_MCYCLE;
            5'd10: return CSR_MINSTRET;
            5'd11: return CSR_CYCLE;
            5'd12: return CSR_TIME;
            5'd13: return CSR_INSTRET;
            5'd14: return CSR_MVENDORID;
            5'd15: return CSR_MARCHID;
            5'd16: return CSR_MIMPID;
            5'd17: return CSR_MHARTID;
            // No register behind these
            5'd24: return 12'h7C0;
            5'd25: return 12'h123;
            5'd26: return 12'h306;
            5'd27: return 12'hFFF;
            5'd28: return 12'h100;
            default: return 12'hC03;
        endcase
    endfunction

    // Outputs are settled at the falling edge
    task automatic compare_cycle();
        wb_t ewb;
        redirect_t eredir;
        check_value("priv", 64'(priv), 64'(m_priv));
        model_cycle(instr_valid, instr, pc, rs1_data, inst_retired, mtime_int, platform_ints,
                    ewb, eredir);
        check_value("wb.valid", 64'(wb.valid), 64'(ewb.valid));
        check_value("redirect.valid", 64'(redirect.valid), 64'(eredir.valid));
        if (ewb.valid) begin
            check_value("wb.rd", 64'(wb.rd), 64'(ewb.rd));
            check_value("wb.data", wb.data, ewb.data);
        end
        if (eredir.valid) begin
            check_value("redirect.pc", redirect.pc, eredir.pc);
            next_pc = eredir.pc;
        end else if (instr_valid) begin
            next_pc = pc + 64'd4;
        end
    endtask

    task automatic issue(input logic valid, input logic [31:0] word, input logic [63:0] src,
                         input logic retired);
        @(posedge clk);
        instr_valid <= valid;
        instr <= word;
        pc <= next_pc;
        rs1_data <= src;
        inst_retired <= retired;
        mtime_int <= mtime_next;
        platform_ints <= plat_next;
        @(negedge clk);
        compare_cycle();
    endtask

    initial begin
        logic [3:0] pick;
        logic [31:0] word;
        logic [2:0] sel_f3;
        logic [11:0] sel_addr;
        logic [4:0] sel_rd;
        logic [4:0] sel_rs1;
        logic [3:0] line;
        logic [63:0] first_cycle;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        rs1_data = '0;
        inst_retired = 1'b0;
        mtime_int = 1'b0;
        platform_ints = '0;
        lfsr = 32'h9c;
        next_pc = 64'h8000_0000;
        mtime_next = 1'b0;
        plat_next = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("wb.valid after reset", 64'(wb.valid), 64'd0);
        check_value("redirect.valid after reset", 64'(redirect.valid), 64'd0);
        check_value("priv after reset", 64'(priv), 64'(PRIV_M));
        compare_cycle();

        // ECALL from M, return to U, then traps taken from U
        issue(1'b1, csr_word(F3_CSRRW, CSR_MTVEC, 5'd1, 5'd2), 64'h4101, 1'b0);
        issue(1'b1, csr_word(F3_CSRRW, CSR_MSCRATCH, 5'd2, 5'd3), 64'h0123_4567_89ab_cdef, 1'b1);
        issue(1'b1, csr_word(F3_CSRRS, CSR_MSCRATCH, 5'd3, 5'd0), 64'h0, 1'b0);
        issue(1'b1, 32'h0000_0073, 64'h0, 1'b0);
        issue(1'b1, csr_word(F3_CSRRC, CSR_MSTATUS, 5'd0, 5'd4), 64'h1800, 1'b0);
        issue(1'b1, csr_word(F3_CSRRW, CSR_MEPC, 5'd0, 5'd5), 64'h8000_0200, 1'b0);
        issue(1'b1, 32'h3020_0073, 64'h0, 1'b0);
        issue(1'b1, csr_word(F3_CSRRS, CSR_MSCRATCH, 5'd6, 5'd0), 64'h0, 1'b0);
        check_value("priv in user mode", 64'(priv), 64'(PRIV_U));
        issue(1'b1, 32'h3020_0073, 64'h0, 1'b0);
        issue(1'b1, 32'h0000_0073, 64'h0, 1'b1);
        issue(1'b1, csr_word(F3_CSRRS, CSR_MCAUSE, 5'd7, 5'd0), 64'h0, 1'b0);

        // Free running cycle counter
        issue(1'b1, csr_word(F3_CSRRS, CSR_CYCLE, 5'd8, 5'd0), 64'h0, 1'b0);
        first_cycle = wb.data;
        issue(1'b1, csr_word(F3_CSRRS, CSR_CYCLE, 5'd8, 5'd0), 64'h0, 1'b0);
        check_value("cycle increases", 64'(wb.data > first_cycle), 64'd1);

        // Timer interrupt replaces the next valid instruction
        issue(1'b1, csr_word(F3_CSRRS, CSR_MIE, 5'd0, 5'd9), 64'h0001_0080, 1'b0);
        issue(1'b1, csr_word(F3_CSRRSI, CSR_MSTATUS, 5'd0, 5'd8), 64'h0, 1'b0);
        mtime_next = 1'b1;
        repeat (3) issue(1'b0, 32'h0, 64'h0, 1'b0);
        issue(1'b1, csr_word(F3_CSRRS, CSR_MSCRATCH, 5'd10, 5'd0), 64'h0, 1'b0);
        check_value("redirect.valid on interrupt", 64'(redirect.valid), 64'd1);
        mtime_next = 1'b0;
        issue(1'b1, csr_word(F3_CSRRS, CSR_MSTATUS, 5'd11, 5'd0), 64'h0, 1'b0);

        for (int slot = 0; slot < NUM_SLOTS; slot++) begin
            if (rand_bits(6) == 32'd0) begin
                mtime_next = !mtime_next;
            end
            if (rand_bits(7) == 32'd0) begin
                line = 4'(rand_bits(4));
                plat_next[line] = !plat_next[line];
            end
            pick = 4'(rand_bits(4));
            sel_f3 = 3'(rand_bits(3));
            sel_addr = pick_addr(5'(rand_bits(5)));
            sel_rd = 5'(rand_bits(3));
            sel_rs1 = 5'(rand_bits(5));
            word = csr_word(sel_f3, sel_addr, sel_rd, sel_rs1);
            if (pick == 4'd12) begin
                word = 32'h0000_0073;
            end else if (pick == 4'd13) begin
                word = 32'h0010_0073;
            end else if (pick == 4'd14) begin
                word = 32'h3020_0073;
            end else if (pick == 4'd15) begin
                word = rand_bits(32);
            end
            issue(pick >= 4'd3, word, {rand_bits(32), rand_bits(32)}, rand_bits(1) != 32'd0);
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* src/sys_unit.sv */
`timescale 1ns/100ps

module sys_unit import sys_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic instr_valid,
    input  logic [31:0] instr,
    input  logic [ALEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic inst_retired,
    input  logic mtime_int,
    input  logic [PLATFORM_INTR_LEN-1:0] platform_ints,
    output wb_t wb,
    output redirect_t redirect,
    output logic [1:0] priv
);

    sys_op_t op;
    logic [XLEN-1:0] rdata;
    logic csr_exc;
    csr_state_t state;
    trap_upd_t trap;
    xret_upd_t xret;

    sys_decode i_sys_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .op          (op)
    );

    csr_file i_csr_file (
        .clk           (clk),
        .rst           (rst),
        .op            (op),
        .rs1_data      (rs1_data),
        .inst_retired  (inst_retired),
        .mtime_int     (mtime_int),
        .platform_ints (platform_ints),
        .trap          (trap),
        .xret          (xret),
        .rdata         (rdata),
        .csr_exc       (csr_exc),
        .state         (state)
    );

    // Result stage closes the loop back into the CSR file
    trap_unit i_trap_unit (
        .op       (op),
        .pc       (pc),
        .csr_exc  (csr_exc),
        .rdata    (rdata),
        .state    (state),
        .trap     (trap),
        .xret     (xret),
        .wb       (wb),
        .redirect (redirect)
    );

    assign priv = state.priv;

endmodule

/* src/trap_unit.sv */
`timescale 1ns/100ps

module trap_unit import sys_pkg::*; (
    input  sys_op_t op,
    input  logic [ALEN-1:0] pc,
    input  logic csr_exc,
    input  logic [XLEN-1:0] rdata,
    input  csr_state_t state,
    output trap_upd_t trap,
    output xret_upd_t xret,
    output wb_t wb,
    output redirect_t redirect
);

    logic [INTR_LEN-1:0] irq_bits;
    logic take_irq;
    logic take_exc;
    logic [5:0] exc_code;
    logic [XLEN-1:0] mret_mstatus;

    // Platform lines first, lowest number wins, timer last
    function automatic logic [5:0] irq_code(input logic [INTR_LEN-1:0] pending);
        logic [5:0] code;
        logic found;
        code = INT_MTI;
        found = 1'b0;
        for (int i = 0; i < PLATFORM_INTR_LEN; i++) begin
            if (!found && pending[16 + i]) begin
                code = 6'(16 + i);
                found = 1'b1;
            end
        end
        return code;
    endfunction

    assign irq_bits = state.mip & state.mie;
    assign take_irq = op.valid && state.mstatus[MS_MIE] && (irq_bits != '0);

    always_comb begin
        take_exc = op.valid;
        exc_code = EXC_ILLEGAL_INSTR;
        if (op.kind == SYS_ILLEGAL || (op.kind == SYS_CSR && csr_exc)) begin
            exc_code = EXC_ILLEGAL_INSTR;
        end else if (op.kind == SYS_ECALL) begin
            exc_code = (state.priv == PRIV_M) ? EXC_ECALL_M : EXC_ECALL_U;
        end else if (op.kind == SYS_EBREAK) begin
            exc_code = EXC_BREAKPOINT;
        end else begin
            take_exc = 1'b0;
        end
    end

    // MIE from MPIE, MPIE set, MPP back to U
    always_comb begin
        mret_mstatus = state.mstatus;
        mret_mstatus[MS_MIE] = state.mstatus[MS_MPIE];
        mret_mstatus[MS_MPIE] = 1'b1;
        mret_mstatus[MS_MPP +: 2] = PRIV_U;
    end

    always_comb begin
        trap = '0;
        wb = '0;
        redirect = '0;
        xret.do_update = 1'b0;
        xret.new_mstatus = mret_mstatus;
        xret.new_priv = state.mstatus[MS_MPP +: 2];
        trap.mepc = pc;

        if (take_irq) begin
            trap.do_update = 1'b1;
            trap.mcause = {1'b1, {(XLEN-7){1'b0}}, irq_code(irq_bits)};
        end else if (take_exc) begin
            trap.do_update = 1'b1;
            trap.mcause = {1'b0, {(XLEN-7){1'b0}}, exc_code};
            if (op.kind == SYS_EBREAK) begin
                trap.mtval = XLEN'(pc);
            end
        end else if (op.valid && op.kind == SYS_MRET) begin
            xret.do_update = 1'b1;
            redirect.valid = 1'b1;
            redirect.pc = state.mepc;
        end else if (op.valid && op.kind == SYS_CSR) begin
            wb.valid = op.does_read && (op.rd != 5'd0);
            wb.rd = op.rd;
            wb.data = rdata;
        end

        if (trap.do_update) begin
            redirect.valid = 1'b1;
            redirect.pc = {state.mtvec[ALEN-1:2], 2'b00};
        end
    end

    always_comb begin
        a_wb_xor_redirect: assert final (!(wb.valid && redirect.valid));
    end

endmodule

/* src/csr_file.sv */
`timescale 1ns/100ps

module csr_file import sys_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  sys_op_t op,
    input  logic [XLEN-1:0] rs1_data,
    input  logic inst_retired,
    input  logic mtime_int,
    input  logic [PLATFORM_INTR_LEN-1:0] platform_ints,
    input  trap_upd_t trap,
    input  xret_upd_t xret,
    output logic [XLEN-1:0] rdata,
    output logic csr_exc,
    output csr_state_t state
);

    logic [1:0] priv;
    logic [XLEN-1:0] mstatus;
    logic [INTR_LEN-1:0] mie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [ALEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [INTR_LEN-1:0] mip;
    logic [XLEN-1:0] mcycle;
    logic [XLEN-1:0] minstret;

    logic mtime_buf;
    logic [PLATFORM_INTR_LEN-1:0] platform_buf;
    logic [INTR_LEN-1:0] mip_or;

    logic bad_addr;
    logic [XLEN-1:0] wsrc;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] mstatus_wr;
    logic csr_we;

    // Timer bit comes only from the buffered line while platform bits stay sticky
    assign mip_or = {platform_buf, 8'b0, mtime_buf, 7'b0};

    // Read mux
    always_comb begin
        bad_addr = 1'b0;
        case (op.csr_addr)
            CSR_MSTATUS: rdata = mstatus;
            CSR_MISA: rdata = MISA_VALUE;
            CSR_MIE: rdata = XLEN'(mie);
            CSR_MTVEC: rdata = mtvec;
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MEPC: rdata = XLEN'(mepc);
            CSR_MCAUSE: rdata = mcause;
            CSR_MTVAL: rdata = mtval;
            CSR_MIP: rdata = XLEN'(mip);
            CSR_MCYCLE, CSR_CYCLE, CSR_TIME: rdata = mcycle;
            CSR_MINSTRET, CSR_INSTRET: rdata = minstret;
            CSR_MVENDORID: rdata = MVENDORID;
            CSR_MARCHID: rdata = MARCHID;
            CSR_MIMPID: rdata = MIMPID;
            CSR_MHARTID: rdata = '0;
            default: begin
                rdata = '0;
                bad_addr = 1'b1;
            end
        endcase
    end

    // Unknown address, write to read-only space, or not enough privilege
    assign csr_exc = op.valid && (op.kind == SYS_CSR)
                     && (bad_addr
                         || (op.does_write && op.csr_addr[11:10] == 2'b11)
                         || (op.csr_addr[9:8] > priv)
                         || (priv == PRIV_U));

    assign wsrc = op.funct3[2] ? XLEN'(op.rs1_uimm) : rs1_data;

    always_comb begin
        case (op.funct3)
            F3_CSRRW, F3_CSRRWI: wdata = wsrc;
            F3_CSRRS, F3_CSRRSI: wdata = rdata | wsrc;
            F3_CSRRC, F3_CSRRCI: wdata = rdata & ~wsrc;
            default: wdata = rdata;
        endcase
        mstatus_wr = wdata & MSTATUS_WMASK;
        // MPP only holds U or M
        mstatus_wr[MS_MPP +: 2] = {2{|wdata[MS_MPP +: 2]}};
    end

    assign csr_we = op.valid && (op.kind == SYS_CSR) && op.does_write
                    && !csr_exc && !trap.do_update;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= PRIV_M;
            mstatus <= MSTATUS_RESET;
            mie <= '0;
            mtvec <= '0;
            mscratch <= '0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
            mip <= '0;
            mcycle <= '0;
            minstret <= '0;
            mtime_buf <= 1'b0;
            platform_buf <= '0;
        end else begin
            mtime_buf <= mtime_int;
            platform_buf <= platform_ints;
            mcycle <= mcycle + 1'b1;
            if (inst_retired) begin
                minstret <= minstret + 1'b1;
            end
            mip <= (mip & MIP_KEEP) | mip_or;

            if (csr_we) begin
                case (op.csr_addr)
                    CSR_MSTATUS: mstatus <= mstatus_wr;
                    CSR_MIE: mie <= wdata[INTR_LEN-1:0] & MIE_WMASK;
                    CSR_MTVEC: mtvec <= wdata & MTVEC_WMASK;
                    CSR_MSCRATCH: mscratch <= wdata;
                    CSR_MEPC: mepc <= wdata[ALEN-1:0] & MEPC_WMASK;
                    CSR_MCAUSE: mcause <= wdata;
                    CSR_MTVAL: mtval <= wdata;
                    // Pending lines are merged so a write cannot drop them
                    CSR_MIP: mip <= (wdata[INTR_LEN-1:0] & MIP_KEEP) | mip_or;
                    CSR_MCYCLE: mcycle <= wdata;
                    CSR_MINSTRET: minstret <= wdata;
                    default: ;
                endcase
            end

            if (xret.do_update) begin
                mstatus <= xret.new_mstatus;
                priv <= xret.new_priv;
            end

            if (trap.do_update) begin
                mcause <= trap.mcause;
                mtval <= trap.mtval;
                if (!xret.do_update) begin
                    mepc <= trap.mepc;
                end
                // Trap always enters M mode
                mstatus[MS_MPP +: 2] <= priv;
                mstatus[MS_MPIE] <= mstatus[MS_MIE];
                mstatus[MS_MIE] <= 1'b0;
                priv <= PRIV_M;
            end
        end
    end

    assign state.priv = priv;
    assign state.mstatus = mstatus;
    assign state.mie = mie;
    assign state.mip = mip;
    assign state.mtvec = mtvec;
    assign state.mepc = mepc;

    // Only an interrupt may replace a legal CSR write
    a_trap_no_write: assert property (@(posedge clk) disable iff (rst)
        (trap.do_update && !trap.mcause[XLEN-1])
        |-> !(op.valid && op.kind == SYS_CSR && op.does_write && !csr_exc));

    a_trap_no_xret: assert property (@(posedge clk) disable iff (rst)
        !(trap.do_update && xret.do_update));

endmodule

/* src/sys_decode.sv */
`timescale 1ns/100ps

module sys_decode import sys_pkg::*; (
    input  logic instr_valid,
    input  logic [31:0] instr,
    output sys_op_t op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [11:0] funct12;
    logic is_write_form;

    // I-type fields, funct12 and CSR address share bits 31..20
    assign opcode = instr[6:0];
    assign rd = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1 = instr[19:15];
    assign funct12 = instr[31:20];

    assign is_write_form = (funct3 == F3_CSRRW) || (funct3 == F3_CSRRWI);

    always_comb begin
        op = '0;
        op.kind = SYS_NONE;
        if (instr_valid) begin
            op.valid = 1'b1;
            op.funct3 = funct3;
            op.csr_addr = funct12;
            op.rd = rd;
            op.rs1_uimm = rs1;
            if (opcode != OPC_SYSTEM) begin
                op.kind = SYS_ILLEGAL;
            end else if (funct3 == 3'b000) begin
                // Privileged forms need rd and rs1 both zero
                if (rd != 5'd0 || rs1 != 5'd0) begin
                    op.kind = SYS_ILLEGAL;
                end else begin
                    case (funct12)
                        F12_ECALL: op.kind = SYS_ECALL;
                        F12_EBREAK: op.kind = SYS_EBREAK;
                        F12_MRET: op.kind = SYS_MRET;
                        default: op.kind = SYS_ILLEGAL;
                    endcase
                end
            end else if (funct3 == 3'b100) begin
                op.kind = SYS_ILLEGAL;
            end else begin
                op.kind = SYS_CSR;
                // Set/clear with a zero source never writes
                op.does_write = is_write_form || (rs1 != 5'd0);
                // Plain write to x0 skips the read
                op.does_read = !is_write_form || (rd != 5'd0);
            end
        end
    end

    // A valid slot always decodes to something, an idle slot to nothing
    always_comb begin
        a_valid_follows: assert final (op.valid == instr_valid
                                       && ((op.kind == SYS_NONE) == !instr_valid));
    end

endmodule

/* src/sys_pkg.sv */
package sys_pkg;

    // Widths
    localparam int XLEN = 64;
    localparam int ALEN = 64;
    localparam int INTR_LEN = 32;
    localparam int PLATFORM_INTR_LEN = 16;

    // Privilege levels
    localparam logic [1:0] PRIV_U = 2'b00;
    localparam logic [1:0] PRIV_M = 2'b11;

    // SYSTEM opcode and privileged funct12 codes
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [11:0] F12_ECALL = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET = 12'h302;

    // Zicsr funct3 codes
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    // CSR addresses
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MISA = 12'h301;
    localparam logic [11:0] CSR_MIE = 12'h304;
    localparam logic [11:0] CSR_MTVEC = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC = 12'h341;
    localparam logic [11:0] CSR_MCAUSE = 12'h342;
    localparam logic [11:0] CSR_MTVAL = 12'h343;
    localparam logic [11:0] CSR_MIP = 12'h344;
    localparam logic [11:0] CSR_MCYCLE = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET = 12'hB02;
    localparam logic [11:0] CSR_CYCLE = 12'hC00;
    localparam logic [11:0] CSR_TIME = 12'hC01;
    localparam logic [11:0] CSR_INSTRET = 12'hC02;
    localparam logic [11:0] CSR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_MARCHID = 12'hF12;
    localparam logic [11:0] CSR_MIMPID = 12'hF13;
    localparam logic [11:0] CSR_MHARTID = 12'hF14;

    // Trap cause codes
    localparam logic [5:0] EXC_ILLEGAL_INSTR = 6'd2;
    localparam logic [5:0] EXC_BREAKPOINT = 6'd3;
    localparam logic [5:0] EXC_ECALL_U = 6'd8;
    localparam logic [5:0] EXC_ECALL_M = 6'd11;
    localparam logic [5:0] INT_MTI = 6'd7;

    // mstatus field positions
    localparam int MS_MIE = 3;
    localparam int MS_MPIE = 7;
    localparam int MS_MPP = 11;

    // Fixed values and write masks
    localparam logic [XLEN-1:0] MVENDORID = 64'h0;
    localparam logic [XLEN-1:0] MARCHID = 64'h0;
    localparam logic [XLEN-1:0] MIMPID = 64'h1;
    // RV64 with A, C, I, M and U
    localparam logic [XLEN-1:0] MISA_VALUE = {2'b10, 36'b0, 26'h0101105};
    localparam logic [XLEN-1:0] MSTATUS_RESET = 64'h1800;
    localparam logic [XLEN-1:0] MSTATUS_WMASK = 64'h1888;
    localparam logic [XLEN-1:0] MTVEC_WMASK = ~64'h3;
    localparam logic [ALEN-1:0] MEPC_WMASK = ~64'h1;
    localparam logic [INTR_LEN-1:0] MIE_WMASK = 32'hFFFF_0080;
    localparam logic [INTR_LEN-1:0] MIP_KEEP = 32'hFFFF_0000;

    typedef enum logic [2:0] {
        SYS_NONE,
        SYS_CSR,
        SYS_ECALL,
        SYS_EBREAK,
        SYS_MRET,
        SYS_ILLEGAL
    } sys_kind_e;

    typedef struct packed {
        logic valid;
        sys_kind_e kind;
        logic [2:0] funct3;
        logic [11:0] csr_addr;
        logic [4:0] rd;
        logic [4:0] rs1_uimm;
        logic does_write;
        logic does_read;
    } sys_op_t;

    typedef struct packed {
        logic do_update;
        logic [XLEN-1:0] mcause;
        logic [ALEN-1:0] mepc;
        logic [XLEN-1:0] mtval;
    } trap_upd_t;

    typedef struct packed {
        logic do_update;
        logic [XLEN-1:0] new_mstatus;
        logic [1:0] new_priv;
    } xret_upd_t;

    typedef struct packed {
        logic [1:0] priv;
        logic [XLEN-1:0] mstatus;
        logic [INTR_LEN-1:0] mie;
        logic [INTR_LEN-1:0] mip;
        logic [XLEN-1:0] mtvec;
        logic [ALEN-1:0] mepc;
    } csr_state_t;

    typedef struct packed {
        logic valid;
        logic [4:0] rd;
        logic [XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic valid;
        logic [ALEN-1:0] pc;
    } redirect_t;

endpackage
